//--- rtl/periph_pkg.sv
// Peripheral subsystem package
// Bus, timer and UART types, register offsets and the APB address map
// shared by the decoder and the timer and UART blocks

package periph_pkg;

	// ------------------------------------------------------------
	// Types

	typedef logic [15:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;
	typedef logic [63:0] mtime_t;
	typedef logic [7:0]  uart_byte_t;
	typedef logic [15:0] clkdiv_t;

	typedef enum logic [1:0] {
		uart_idle,
		uart_start,
		uart_data,
		uart_stop
	} uart_state_t;

	// ------------------------------------------------------------
	// Address map, target chosen by paddr[15:14]

	localparam logic [1:0] sel_timer = 2'd0;
	localparam logic [1:0] sel_uart  = 2'd1;

	// Timer registers
	localparam apb_addr_t timer_ctrl      = 16'h0000;
	localparam apb_addr_t timer_mtime     = 16'h0008;
	localparam apb_addr_t timer_mtimeh    = 16'h000c;
	localparam apb_addr_t timer_mtimecmp  = 16'h0010;
	localparam apb_addr_t timer_mtimecmph = 16'h0014;
	localparam int        ctrl_enable_bit = 0;
	localparam mtime_t    mtimecmp_reset  = '1;

	// UART registers
	localparam apb_addr_t uart_txdata     = 16'h0000;
	localparam apb_addr_t uart_status     = 16'h0004;
	localparam apb_addr_t uart_clkdiv     = 16'h0008;
	localparam int        status_busy_bit = 0;
	localparam clkdiv_t   clkdiv_reset    = 16'd16;

endpackage

//--- rtl/apb_decode.sv
// APB address decoder
// Routes psel to the timer or the UART from paddr[15:14], muxes read data
// back and flags accesses to the unmapped half of the map

`timescale 1ns/1ns

module apb_decode (
	input  logic                  psel,
	input  logic                  penable,
	input  periph_pkg::apb_addr_t paddr,
	input  periph_pkg::apb_data_t timer_prdata,
	input  periph_pkg::apb_data_t uart_prdata,
	output logic                  timer_sel,
	output logic                  uart_sel,
	output periph_pkg::apb_data_t prdata,
	output logic                  pslverr
);

	logic [1:0] target;
	logic       mapped;

	assign target = paddr[15:14];

	assign mapped = (target == periph_pkg::sel_timer) ||
		(target == periph_pkg::sel_uart);

	assign timer_sel = psel && (target == periph_pkg::sel_timer);
	assign uart_sel  = psel && (target == periph_pkg::sel_uart);

	// Error only in the access phase, never in setup
	assign pslverr = psel && penable && !mapped;

	// Unmapped targets read as zero
	always_comb begin
		case (target)
			periph_pkg::sel_timer: prdata = timer_prdata;
			periph_pkg::sel_uart:  prdata = uart_prdata;
			default:               prdata = '0;
		endcase
	end

endmodule

//--- rtl/tick_divider.sv
// Microsecond tick divider
// Emits a one-cycle tick every CLK_MHZ clocks, first one CLK_MHZ clocks
// after reset

`timescale 1ns/1ns

module tick_divider #(
	parameter int CLK_MHZ = 12
) (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	localparam int               cnt_w  = $clog2(CLK_MHZ);
	localparam logic [cnt_w-1:0] reload = cnt_w'(CLK_MHZ - 1);

	logic [cnt_w-1:0] count;

	// Down-counter, tick registered on the cycle it wraps
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= reload;
			tick  <= 1'b0;
		end else begin
			if (|count) begin
				count <= count - 1'b1;
			end else begin
				count <= reload;
			end
			tick <= ~|count;
		end
	end

endmodule

//--- rtl/mtimer.sv
// RISC-V style machine timer
// 64-bit mtime advanced by the microsecond tick while enabled and not
// halted, 64-bit mtimecmp, registered timer interrupt when mtime
// reaches mtimecmp. Word halves are written independently.

`timescale 1ns/1ns

module mtimer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  sel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic                  tick,
	input  logic                  halt,
	input  periph_pkg::apb_addr_t offset,
	input  periph_pkg::apb_data_t pwdata,
	output periph_pkg::apb_data_t prdata,
	output logic                  timer_irq
);

	logic               wr_en;
	logic               ctrl_en;
	periph_pkg::mtime_t mtime;
	periph_pkg::mtime_t mtimecmp;

	// Writes land at the end of the access phase
	assign wr_en = sel && penable && pwrite;

	// ------------------------------------------------------------
	// Registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en <= 1'b0;
		end else if (wr_en && offset == periph_pkg::timer_ctrl) begin
			ctrl_en <= pwdata[periph_pkg::ctrl_enable_bit];
		end
	end

	// A write to either half wins over the tick in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (wr_en && offset == periph_pkg::timer_mtime) begin
			mtime[31:0] <= pwdata;
		end else if (wr_en && offset == periph_pkg::timer_mtimeh) begin
			mtime[63:32] <= pwdata;
		end else if (tick && ctrl_en && !halt) begin
			mtime <= mtime + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp <= periph_pkg::mtimecmp_reset;
		end else if (wr_en && offset == periph_pkg::timer_mtimecmp) begin
			mtimecmp[31:0] <= pwdata;
		end else if (wr_en && offset == periph_pkg::timer_mtimecmph) begin
			mtimecmp[63:32] <= pwdata;
		end
	end

	// Compare is one cycle behind the count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= (mtime >= mtimecmp);
		end
	end

	// ------------------------------------------------------------
	// Read mux

	always_comb begin
		prdata = '0;
		case (offset)
			periph_pkg::timer_ctrl:      prdata[periph_pkg::ctrl_enable_bit] = ctrl_en;
			periph_pkg::timer_mtime:     prdata = mtime[31:0];
			periph_pkg::timer_mtimeh:    prdata = mtime[63:32];
			periph_pkg::timer_mtimecmp:  prdata = mtimecmp[31:0];
			periph_pkg::timer_mtimecmph: prdata = mtimecmp[63:32];
			default:                     prdata = '0;
		endcase
	end

endmodule

//--- rtl/uart_regs.sv
// UART register file
// Transmit data, busy status and the clocks-per-bit divider. A txdata
// write while idle latches the byte and pulses tx_start for one cycle.

`timescale 1ns/1ns

module uart_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   sel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic                   busy,
	input  periph_pkg::apb_addr_t  offset,
	input  periph_pkg::apb_data_t  pwdata,
	output periph_pkg::apb_data_t  prdata,
	output logic                   tx_start,
	output periph_pkg::uart_byte_t tx_byte,
	output periph_pkg::clkdiv_t    clkdiv
);

	logic wr_en;
	logic tx_accept;

	assign wr_en = sel && penable && pwrite;

	// Data written while a frame is pending or in flight is dropped
	assign tx_accept = wr_en && (offset == periph_pkg::uart_txdata) && !busy && !tx_start;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_start <= 1'b0;
			clkdiv   <= periph_pkg::clkdiv_reset;
		end else begin
			tx_start <= tx_accept;
			if (wr_en && offset == periph_pkg::uart_clkdiv) begin
				clkdiv <= pwdata[15:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tx_accept) begin
			tx_byte <= pwdata[7:0];
		end
	end

	// txdata is write-only and reads zero
	always_comb begin
		prdata = '0;
		case (offset)
			periph_pkg::uart_status: prdata[periph_pkg::status_busy_bit] = busy;
			periph_pkg::uart_clkdiv: prdata = {16'h0000, clkdiv};
			default:                 prdata = '0;
		endcase
	end

endmodule

//--- rtl/uart_tx_fsm.sv
// UART transmitter
// Sends one byte as 8N1, LSB first, each bit clkdiv clocks long.
// The divider is captured at start so a frame in flight keeps its rate.

`timescale 1ns/1ns

module uart_tx_fsm (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   tx_start,
	input  periph_pkg::uart_byte_t tx_byte,
	input  periph_pkg::clkdiv_t    clkdiv,
	output logic                   tx,
	output logic                   busy
);

	periph_pkg::uart_state_t state;
	periph_pkg::uart_byte_t  shift;
	periph_pkg::clkdiv_t     div_q;
	periph_pkg::clkdiv_t     start_div;
	periph_pkg::clkdiv_t     bit_cnt;
	logic [2:0]              bit_idx;
	logic                    bit_done;

	// Zero divider behaves as one clock per bit
	assign start_div = (clkdiv == '0) ? 16'd1 : clkdiv;
	assign bit_done  = (bit_cnt == '0);
	assign busy      = (state != periph_pkg::uart_idle);

	// ------------------------------------------------------------
	// Frame sequencing

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= periph_pkg::uart_idle;
			tx      <= 1'b1;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				periph_pkg::uart_idle: begin
					if (tx_start) begin
						state   <= periph_pkg::uart_start;
						tx      <= 1'b0;
						bit_cnt <= start_div - 1'b1;
						bit_idx <= '0;
					end
				end
				periph_pkg::uart_start: begin
					if (bit_done) begin
						state   <= periph_pkg::uart_data;
						tx      <= shift[0];
						bit_cnt <= div_q - 1'b1;
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
				periph_pkg::uart_data: begin
					if (bit_done) begin
						bit_cnt <= div_q - 1'b1;
						if (bit_idx == 3'd7) begin
							state <= periph_pkg::uart_stop;
							tx    <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							tx      <= shift[1];
						end
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
				periph_pkg::uart_stop: begin
					// tx already high, line stays idle afterwards
					if (bit_done) begin
						state <= periph_pkg::uart_idle;
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
				default: state <= periph_pkg::uart_idle;
			endcase
		end
	end

	// Byte and divider captured at frame start
	always_ff @(posedge clk) begin
		if (state == periph_pkg::uart_idle && tx_start) begin
			shift <= tx_byte;
			div_q <= start_div;
		end else if (state == periph_pkg::uart_data && bit_done) begin
			shift <= shift >> 1;
		end
	end

endmodule

//--- rtl/periph_subsys.sv
// APB peripheral subsystem
// An outside APB master reaches a machine timer and a transmit-only UART
// through a combinational address decoder. A microsecond tick divider
// provides the timer timebase. Zero wait states, pready always high.

`timescale 1ns/1ns

module periph_subsys #(
	parameter int CLK_MHZ = 12
) (
	input  logic                 clk,
	input  logic                 rst_n,

	// APB slave
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  periph_pkg::apb_addr_t paddr,
	input  periph_pkg::apb_data_t pwdata,
	output periph_pkg::apb_data_t prdata,
	output logic                 pready,
	output logic                 pslverr,

	// Timer
	input  logic                 halt,
	output logic                 timer_irq,

	// UART
	output logic                 tx
);

	logic                   timer_sel;
	logic                   uart_sel;
	periph_pkg::apb_addr_t  target_offset;
	periph_pkg::apb_data_t  timer_prdata;
	periph_pkg::apb_data_t  uart_prdata;
	logic                   tick;
	logic                   busy;
	logic                   tx_start;
	periph_pkg::uart_byte_t tx_byte;
	periph_pkg::clkdiv_t    clkdiv;

	// No wait states on any target
	assign pready = 1'b1;

	// Targets see the offset inside their 16 kB window
	assign target_offset = {2'b00, paddr[13:0]};

	// ------------------------------------------------------------
	// Bus decode

	apb_decode u_decode (
		.psel         (psel),
		.penable      (penable),
		.paddr        (paddr),
		.timer_prdata (timer_prdata),
		.uart_prdata  (uart_prdata),
		.timer_sel    (timer_sel),
		.uart_sel     (uart_sel),
		.prdata       (prdata),
		.pslverr      (pslverr)
	);

	// ------------------------------------------------------------
	// Timer and its timebase

	tick_divider #(
		.CLK_MHZ (CLK_MHZ)
	) u_tick (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	mtimer u_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.sel       (timer_sel),
		.penable   (penable),
		.pwrite    (pwrite),
		.tick      (tick),
		.halt      (halt),
		.offset    (target_offset),
		.pwdata    (pwdata),
		.prdata    (timer_prdata),
		.timer_irq (timer_irq)
	);

	// ------------------------------------------------------------
	// UART

	uart_regs u_uart_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.sel      (uart_sel),
		.penable  (penable),
		.pwrite   (pwrite),
		.busy     (busy),
		.offset   (target_offset),
		.pwdata   (pwdata),
		.prdata   (uart_prdata),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.clkdiv   (clkdiv)
	);

	uart_tx_fsm u_uart_tx (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.clkdiv   (clkdiv),
		.tx       (tx),
		.busy     (busy)
	);

endmodule

//--- verification/periph_properties.sv
// APB and UART properties for the peripheral subsystem
// Bound into the top level, sees the internal busy and tx_start nets

`timescale 1ns/1ns

module periph_properties (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic tx,
	input logic busy,
	input logic tx_start
);

	// ------------------------------------------------------------
	// APB

	pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
		else $error("pready went low");

	pslverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr |-> (psel && penable))
		else $error("pslverr high outside an access phase");

	// ------------------------------------------------------------
	// UART

	tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx)
		else $error("tx low while the transmitter is idle");

	busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
		tx_start |=> busy)
		else $error("busy did not rise after tx_start");

endmodule

bind periph_subsys periph_properties u_properties (
	.clk      (clk),
	.rst_n    (rst_n),
	.psel     (psel),
	.penable  (penable),
	.pready   (pready),
	.pslverr  (pslverr),
	.tx       (tx),
	.busy     (busy),
	.tx_start (tx_start)
);

//--- verification/tb_periph_subsys.sv
// Testbench for the APB peripheral subsystem
// Seeded random APB stimulus against the timer, the UART and the address
// map. Expected values come from a small model of each block kept here.

`timescale 1ns/1ns

module tb_periph_subsys;

	localparam int                    clk_mhz     = 12;
	localparam periph_pkg::apb_addr_t timer_base  = 16'h0000;
	localparam periph_pkg::apb_addr_t uart_base   = 16'h4000;
	// Cycles between the two low-word samples of back-to-back mtime reads
	localparam int                    read_cycles = 6;
	localparam int                    poll_limit  = 64 * clk_mhz;

	logic                  clk;
	logic                  rst_n;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	periph_pkg::apb_addr_t paddr;
	periph_pkg::apb_data_t pwdata;
	periph_pkg::apb_data_t prdata;
	logic                  pready;
	logic                  pslverr;
	logic                  halt;
	logic                  timer_irq;
	logic                  tx;

	integer seed = 36;
	int     error_count = 0;

	periph_subsys #(
		.CLK_MHZ (clk_mhz)
	) UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.halt      (halt),
		.timer_irq (timer_irq),
		.tx        (tx)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------------------------------------
	// Error reporting and compare tasks

	task automatic fail_run(input string msg);
		error_count++;
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input string name, input periph_pkg::apb_data_t exp,
			input periph_pkg::apb_data_t act);
		if (act !== exp)
			fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_time(input string name, input periph_pkg::mtime_t exp,
			input periph_pkg::mtime_t act);
		if (act !== exp)
			fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_byte(input string name, input periph_pkg::uart_byte_t exp,
			input periph_pkg::uart_byte_t act);
		if (act !== exp)
			fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
	endtask

	function automatic periph_pkg::apb_data_t next_random();
		next_random = $random(seed);
	endfunction

	// ------------------------------------------------------------
	// APB master, setup then access, then back to idle

	task automatic apb_write(input periph_pkg::apb_addr_t addr,
			input periph_pkg::apb_data_t data);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// Read data and error sampled mid access phase
	task automatic apb_read(input periph_pkg::apb_addr_t addr,
			output periph_pkg::apb_data_t data, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		err  = pslverr;
		check_bit("pready in access phase", 1'b1, pready);
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_check(input periph_pkg::apb_addr_t addr,
			input periph_pkg::apb_data_t exp, input string name);
		periph_pkg::apb_data_t data;
		logic                  err;
		apb_read(addr, data, err);
		check_data(name, exp, data);
		check_bit({name, " pslverr"}, 1'b0, err);
	endtask

	task automatic write_time(input periph_pkg::apb_addr_t addr,
			input periph_pkg::mtime_t value);
		apb_write(addr, value[31:0]);
		apb_write(addr + 16'd4, value[63:32]);
	endtask

	task automatic read_time(input periph_pkg::apb_addr_t addr,
			output periph_pkg::mtime_t value);
		periph_pkg::apb_data_t lo;
		periph_pkg::apb_data_t hi;
		logic                  err;
		apb_read(addr, lo, err);
		check_bit("64-bit low read pslverr", 1'b0, err);
		apb_read(addr + 16'd4, hi, err);
		check_bit("64-bit high read pslverr", 1'b0, err);
		value = {hi, lo};
	endtask

	// ------------------------------------------------------------
	// Tests

	task automatic test_reset();
		periph_pkg::mtime_t    value;
		periph_pkg::mtime_t    written;
		periph_pkg::apb_data_t data;
		@(negedge clk);
		check_bit("reset tx", 1'b1, tx);
		check_bit("reset timer_irq", 1'b0, timer_irq);
		check_bit("reset pslverr", 1'b0, pslverr);
		read_check(uart_base + periph_pkg::uart_status, 32'h0, "reset status");
		read_time(timer_base + periph_pkg::timer_mtimecmp, value);
		check_time("reset mtimecmp", {64{1'b1}}, value);
		read_check(uart_base + periph_pkg::uart_clkdiv, 32'd16, "reset clkdiv");
		repeat (4) begin
			written = {next_random(), next_random()};
			write_time(timer_base + periph_pkg::timer_mtimecmp, written);
			read_time(timer_base + periph_pkg::timer_mtimecmp, value);
			check_time("mtimecmp readback", written, value);
			data = next_random();
			apb_write(uart_base + periph_pkg::uart_clkdiv, data);
			read_check(uart_base + periph_pkg::uart_clkdiv, {16'h0000, data[15:0]},
				"clkdiv readback");
		end
		write_time(timer_base + periph_pkg::timer_mtimecmp, {64{1'b1}});
		apb_write(uart_base + periph_pkg::uart_clkdiv, 32'd16);
	endtask

	task automatic test_unmapped();
		periph_pkg::apb_data_t data;
		periph_pkg::apb_addr_t addr;
		logic                  err;
		repeat (8) begin
			data = next_random();
			addr = data[15:0];
			addr[15] = 1'b1;
			apb_read(addr, data, err);
			check_bit("unmapped pslverr", 1'b1, err);
			check_data("unmapped prdata", 32'h0, data);
			// Same offset in the timer or UART window
			addr[15] = 1'b0;
			apb_read(addr, data, err);
			check_bit("mapped pslverr", 1'b0, err);
		end
	endtask

	task automatic test_timer();
		periph_pkg::mtime_t t0;
		periph_pkg::mtime_t t1;
		periph_pkg::mtime_t step;
		int                 k;
		k = 3 + next_random() % 8;
		apb_write(timer_base + periph_pkg::timer_ctrl, 32'h1);
		read_check(timer_base + periph_pkg::timer_ctrl, 32'h1, "ctrl enable readback");
		read_time(timer_base + periph_pkg::timer_mtime, t0);
		repeat (k * clk_mhz - read_cycles) @(posedge clk);
		read_time(timer_base + periph_pkg::timer_mtime, t1);
		step = t1 - t0;
		check_bit($sformatf("mtime advance over %0d ticks", k), 1'b1,
			step >= k - 1 && step <= k + 1);

		// Halt freezes the count with enable still set
		@(posedge clk);
		halt <= 1'b1;
		read_time(timer_base + periph_pkg::timer_mtime, t0);
		repeat (3 * clk_mhz) @(posedge clk);
		read_time(timer_base + periph_pkg::timer_mtime, t1);
		check_time("mtime frozen by halt", t0, t1);
		@(posedge clk);
		halt <= 1'b0;

		apb_write(timer_base + periph_pkg::timer_ctrl, 32'h0);
		read_time(timer_base + periph_pkg::timer_mtime, t0);
		repeat (3 * clk_mhz) @(posedge clk);
		read_time(timer_base + periph_pkg::timer_mtime, t1);
		check_time("mtime frozen while disabled", t0, t1);

		t0 = {next_random(), next_random()};
		write_time(timer_base + periph_pkg::timer_mtime, t0);
		read_time(timer_base + periph_pkg::timer_mtime, t1);
		check_time("mtime readback while disabled", t0, t1);
	endtask

	task automatic test_irq();
		periph_pkg::apb_data_t data;
		periph_pkg::mtime_t    now;
		periph_pkg::mtime_t    cmp;
		int                    delta;
		int                    waited;
		apb_write(timer_base + periph_pkg::timer_ctrl, 32'h0);
		data = next_random();
		write_time(timer_base + periph_pkg::timer_mtime, {54'h0, data[9:0]});
		apb_write(timer_base + periph_pkg::timer_ctrl, 32'h1);
		read_time(timer_base + periph_pkg::timer_mtime, now);
		delta = 5 + next_random() % 36;
		cmp = now + delta;
		// High word parked at all ones so the low write cannot fire early
		apb_write(timer_base + periph_pkg::timer_mtimecmph, 32'hffff_ffff);
		apb_write(timer_base + periph_pkg::timer_mtimecmp, cmp[31:0]);
		apb_write(timer_base + periph_pkg::timer_mtimecmph, cmp[63:32]);
		// Registered compare needs one clock to see the new mtimecmp
		repeat (2) @(negedge clk);
		check_bit("timer_irq before compare", 1'b0, timer_irq);
		waited = 0;
		while (timer_irq !== 1'b1) begin
			if (waited >= poll_limit)
				fail_run("timer_irq never rose after mtime reached mtimecmp");
			waited++;
			@(negedge clk);
		end
		read_time(timer_base + periph_pkg::timer_mtime, now);
		check_bit("mtime at or above mtimecmp", 1'b1, now >= cmp);

		apb_write(timer_base + periph_pkg::timer_mtimecmph, 32'hffff_ffff);
		waited = 0;
		@(negedge clk);
		while (timer_irq !== 1'b0) begin
			if (waited >= 8)
				fail_run("timer_irq stayed high after mtimecmp was raised");
			waited++;
			@(negedge clk);
		end
		apb_write(timer_base + periph_pkg::timer_ctrl, 32'h0);
	endtask

	// Finds the start edge, then samples every bit at its centre
	task automatic capture_frame(input int div, input periph_pkg::uart_byte_t exp);
		periph_pkg::uart_byte_t got;
		int                     waited;
		int                     i;
		got = '0;
		waited = 0;
		@(negedge clk);
		while (tx !== 1'b0) begin
			if (waited >= 64)
				fail_run("no start bit on tx after the txdata write");
			waited++;
			@(negedge clk);
		end
		repeat (div / 2) @(negedge clk);
		check_bit("uart start bit", 1'b0, tx);
		for (i = 0; i < 8; i++) begin
			repeat (div) @(negedge clk);
			got[i] = tx;
		end
		check_byte("uart data bits", exp, got);
		repeat (div) @(negedge clk);
		check_bit("uart stop bit", 1'b1, tx);
	endtask

	task automatic test_uart();
		periph_pkg::apb_data_t  data;
		periph_pkg::uart_byte_t first;
		periph_pkg::uart_byte_t second;
		logic                   err;
		int                     div;
		int                     waited;
		int                     i;
		div = 2 + next_random() % 19;
		data = next_random();
		first = data[7:0];
		data = next_random();
		second = data[7:0];
		apb_write(uart_base + periph_pkg::uart_clkdiv, div);
		apb_write(uart_base + periph_pkg::uart_txdata, {24'h0, first});
		fork
			capture_frame(div, first);
			begin
				read_check(uart_base + periph_pkg::uart_status, 32'h1, "status busy");
				apb_write(uart_base + periph_pkg::uart_txdata, {24'h0, second});
			end
		join
		waited = 0;
		apb_read(uart_base + periph_pkg::uart_status, data, err);
		while (data !== 32'h0) begin
			if (waited >= 40)
				fail_run("UART status stayed busy after the frame");
			waited++;
			apb_read(uart_base + periph_pkg::uart_status, data, err);
		end
		check_bit("status poll pslverr", 1'b0, err);
		// A second frame would pull tx low here
		for (i = 0; i < 12 * div; i++) begin
			@(negedge clk);
			check_bit("tx idle after dropped write", 1'b1, tx);
		end
	endtask

	// ------------------------------------------------------------
	// Sequence

	initial begin
		rst_n   <= 1'b0;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		halt    <= 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		test_reset();
		test_unmapped();
		test_timer();
		test_irq();
		repeat (3) test_uart();
		@(posedge clk);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- periph_subsys.f
rtl/periph_pkg.sv
rtl/apb_decode.sv
rtl/tick_divider.sv
rtl/mtimer.sv
rtl/uart_regs.sv
rtl/uart_tx_fsm.sv
rtl/periph_subsys.sv
verification/periph_properties.sv
verification/tb_periph_subsys.sv

//--- Bender.yml
package:
  name: periph_subsys

sources:
  - rtl/periph_pkg.sv
  - rtl/apb_decode.sv
  - rtl/tick_divider.sv
  - rtl/mtimer.sv
  - rtl/uart_regs.sv
  - rtl/uart_tx_fsm.sv
  - rtl/periph_subsys.sv
  - target: simulation
    files:
      - verification/periph_properties.sv
      - verification/tb_periph_subsys.sv
